// File: hw/fetch_ctrl.sv
`timescale 1ns/10ps

module fetch_ctrl import fetch_pkg::*; (
  input  logic              clk,
  input  logic              rst_n_i,
  input  logic [ADDR_W-1:0] pc_i,
  input  logic              trap_valid_i,
  input  logic              branch_valid_i,
  input  logic              restart_i,
  input  logic              q_full_i,
  input  apb_rsp_t          apb_rsp_i,
  output apb_req_t          apb_req_o,
  output fetch_ctrl_t       ctrl_o
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_SETUP,
    ST_ACCESS
  } state_e;

  state_e            state_q;
  state_e            state_d;
  logic              stale_q;
  logic [ADDR_W-1:0] addr_q;
  logic              redirect;
  logic              done;
  logic              keep;

  assign redirect = restart_i | trap_valid_i | branch_valid_i;
  assign done     = (state_q == ST_ACCESS) & apb_rsp_i.pready;

  // drop the response if the pc moved under it, now or earlier
  assign keep = done & ~stale_q & ~redirect;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (!q_full_i) begin
          state_d = ST_SETUP;
        end
      end
      ST_SETUP: begin
        state_d = ST_ACCESS;
      end
      ST_ACCESS: begin
        if (apb_rsp_i.pready) begin
          // back-to-back unless the queue has no room left
          state_d = q_full_i ? ST_IDLE : ST_SETUP;
        end
      end
      default: begin
        state_d = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= ST_IDLE;
      stale_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (done) begin
        stale_q <= 1'b0;
      end else if (redirect && state_q != ST_IDLE) begin
        stale_q <= 1'b1;  // transfer in flight is now for an old pc
      end
    end
  end

  // address captured at setup, held through access
  always_ff @(posedge clk) begin
    if (state_q == ST_SETUP) begin
      addr_q <= pc_i;
    end
  end

  always_comb begin
    apb_req_o.psel    = (state_q != ST_IDLE);
    apb_req_o.penable = (state_q == ST_ACCESS);
    apb_req_o.paddr   = (state_q == ST_SETUP) ? pc_i : addr_q;
  end

  always_comb begin
    ctrl_o.pc_stall = ~keep;      // pc advances once per kept fetch
    ctrl_o.pc_flush = restart_i;
    ctrl_o.q_flush  = redirect;
    ctrl_o.q_push   = keep;
  end

endmodule

// File: hw/fetch_pkg.sv
package fetch_pkg;

  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;

  localparam logic [ADDR_W-1:0] PC_RESET_ADDR = 32'h8000_0000;

  // fetch queue sizing, depth kept a power of two
  localparam int FQ_DEPTH = 4;
  localparam int FQ_PTR_W = $clog2(FQ_DEPTH);
  localparam int FQ_CNT_W = FQ_PTR_W + 1;

  localparam logic [6:0] OPC_JAL = 7'b1101111;

  typedef struct packed {
    logic              valid;
    logic              plus4;  // fence.i, resume after it
    logic [ADDR_W-1:0] pc;
  } redirect_t;

  typedef struct packed {
    logic              valid;
    logic [ADDR_W-1:0] pc;
  } branch_t;

  typedef struct packed {
    logic              taken;
    logic [ADDR_W-1:0] target;
  } pred_t;

  typedef struct packed {
    logic pc_stall;
    logic pc_flush;
    logic q_flush;
    logic q_push;
  } fetch_ctrl_t;

  typedef struct packed {
    logic [ADDR_W-1:0] pc;
    logic [DATA_W-1:0] inst;
    logic              pred_taken;
    logic              fault;    // pslverr on this fetch
  } fetch_entry_t;

  typedef struct packed {
    logic              psel;
    logic              penable;
    logic [ADDR_W-1:0] paddr;
  } apb_req_t;

  typedef struct packed {
    logic              pready;
    logic [DATA_W-1:0] prdata;
    logic              pslverr;
  } apb_rsp_t;

endpackage

// File: hw/fetch_queue.sv
`timescale 1ns/10ps

module fetch_queue import fetch_pkg::*; (
  input  logic         clk,
  input  logic         rst_n_i,
  input  logic         push_i,
  input  logic         flush_i,
  input  fetch_entry_t entry_i,
  output logic         full_o,
  output logic         deq_valid_o,
  output fetch_entry_t deq_entry_o,
  input  logic         deq_ready_i
);

  fetch_entry_t        mem_q [FQ_DEPTH];
  logic [FQ_PTR_W-1:0] rd_ptr_q;
  logic [FQ_PTR_W-1:0] wr_ptr_q;
  logic [FQ_CNT_W-1:0] count_q;
  logic                empty;
  logic                at_cap;
  logic                pop;
  logic                wr_en;

  assign empty  = (count_q == '0);
  assign at_cap = (count_q == FQ_CNT_W'(FQ_DEPTH));
  assign pop    = ~empty & deq_ready_i;
  assign wr_en  = push_i & ~at_cap;

  // look-ahead full, so a fetch is never started without a free slot
  assign full_o = at_cap |
                  ((count_q == FQ_CNT_W'(FQ_DEPTH - 1)) & push_i & ~pop);

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      rd_ptr_q <= '0;  // flush beats a same-cycle push
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      if (wr_en && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !wr_en) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en && !flush_i) begin
      mem_q[wr_ptr_q] <= entry_i;
    end
  end

  assign deq_valid_o = ~empty;
  assign deq_entry_o = mem_q[rd_ptr_q];

endmodule

// File: hw/fetch_top.sv
`timescale 1ns/10ps

module fetch_top import fetch_pkg::*; (
  input  logic         clk,
  input  logic         rst_n_i,
  input  redirect_t    trap_i,
  input  branch_t      branch_i,
  input  logic         restart_i,
  output apb_req_t     apb_o,
  input  apb_rsp_t     apb_i,
  output logic         deq_valid_o,
  output fetch_entry_t deq_entry_o,
  input  logic         deq_ready_i
);

  logic [ADDR_W-1:0] pc;
  fetch_ctrl_t       ctrl;
  pred_t             pred;
  fetch_entry_t      entry;
  logic              q_full;
  logic              bpu_valid;

  pc_reg u_pc_reg (
    .clk      (clk),
    .rst_n_i  (rst_n_i),
    .ctrl_i   (ctrl),
    .trap_i   (trap_i),
    .branch_i (branch_i),
    .pred_i   (pred),
    .pc_o     (pc)
  );

  fetch_ctrl u_fetch_ctrl (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .pc_i           (pc),
    .trap_valid_i   (trap_i.valid),
    .branch_valid_i (branch_i.valid),
    .restart_i      (restart_i),
    .q_full_i       (q_full),
    .apb_rsp_i      (apb_i),
    .apb_req_o      (apb_o),
    .ctrl_o         (ctrl)
  );

  assign bpu_valid = ctrl.q_push & ~apb_i.pslverr;  // no prediction on a faulted word

  static_bpu u_static_bpu (
    .pc_i    (pc),
    .inst_i  (apb_i.prdata),
    .valid_i (bpu_valid),
    .pred_o  (pred)
  );

  always_comb begin
    entry.pc         = pc;
    entry.inst       = apb_i.prdata;
    entry.pred_taken = pred.taken;
    entry.fault      = apb_i.pslverr;
  end

  fetch_queue u_fetch_queue (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .push_i      (ctrl.q_push),
    .flush_i     (ctrl.q_flush),
    .entry_i     (entry),
    .full_o      (q_full),
    .deq_valid_o (deq_valid_o),
    .deq_entry_o (deq_entry_o),
    .deq_ready_i (deq_ready_i)
  );

endmodule

// File: hw/pc_reg.sv
`timescale 1ns/10ps

module pc_reg import fetch_pkg::*; (
  input  logic              clk,
  input  logic              rst_n_i,
  input  fetch_ctrl_t       ctrl_i,
  input  redirect_t         trap_i,
  input  branch_t           branch_i,
  input  pred_t             pred_i,
  output logic [ADDR_W-1:0] pc_o
);

  logic [ADDR_W-1:0] pc_q;
  logic [ADDR_W-1:0] pc_plus4;
  logic [ADDR_W-1:0] trap_pc;
  logic [ADDR_W-1:0] pc_next;
  logic              redirect;
  logic              pc_wen;

  assign pc_plus4 = pc_q + ADDR_W'(4);

  // fence.i restarts at the instruction after itself
  assign trap_pc = trap_i.plus4 ? trap_i.pc + ADDR_W'(4) : trap_i.pc;

  assign redirect = trap_i.valid | branch_i.valid;

  // trap > branch > jal prediction > sequential
  always_comb begin
    if (trap_i.valid) begin
      pc_next = trap_pc;
    end else if (branch_i.valid) begin
      pc_next = branch_i.pc;
    end else if (pred_i.taken) begin
      pc_next = pred_i.target;
    end else begin
      pc_next = pc_plus4;
    end
  end

  // redirects load even while the fetch side is stalled
  assign pc_wen = redirect | ~ctrl_i.pc_stall;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pc_q <= PC_RESET_ADDR;
    end else if (ctrl_i.pc_flush) begin
      pc_q <= PC_RESET_ADDR;  // restart
    end else if (pc_wen) begin
      pc_q <= pc_next;
    end
  end

  assign pc_o = pc_q;

endmodule

// File: hw/static_bpu.sv
`timescale 1ns/10ps

module static_bpu import fetch_pkg::*; (
  input  logic [ADDR_W-1:0] pc_i,
  input  logic [DATA_W-1:0] inst_i,
  input  logic              valid_i,
  output pred_t             pred_o
);

  logic [6:0]        opcode;
  logic              is_jal;
  logic [ADDR_W-1:0] j_imm;
  logic [ADDR_W-1:0] target;

  assign opcode = inst_i[6:0];
  assign is_jal = (opcode == OPC_JAL);

  // j-type immediate, bit 0 always zero
  assign j_imm = {
    {(ADDR_W - 20){inst_i[31]}},
    inst_i[19:12],
    inst_i[20],
    inst_i[30:21],
    1'b0
  };

  assign target = pc_i + j_imm;

  // only a clean completion may steer the pc
  always_comb begin
    pred_o.taken  = valid_i & is_jal;
    pred_o.target = target;
  end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module fetch_tb -o fetch_sim

out=$(./obj_dir/fetch_sim)
echo "$out"

if echo "$out" | grep -q "SIMULATION PASSED"; then
  exit 0
else
  exit 1
fi

// File: src.f
hw/fetch_pkg.sv
hw/pc_reg.sv
hw/fetch_ctrl.sv
hw/static_bpu.sv
hw/fetch_queue.sv
hw/fetch_top.sv
verification/clk_gen.sv
verification/imem_apb_model.sv
verification/fetch_assert.sv
verification/fetch_tb.sv

// File: verification/clk_gen.sv
`timescale 1ns/10ps

module clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  initial clk_o = 1'b0;
  always #2 clk_o = ~clk_o;  // 4 ns period

  initial begin
    rst_n_o = 1'b0;
    repeat (2) @(posedge clk_o);
    #1 rst_n_o = 1'b1;
  end

endmodule

// File: verification/fetch_assert.sv
`timescale 1ns/10ps

module fetch_assert import fetch_pkg::*; (
  input logic        clk,
  input logic        rst_n_i,
  input apb_req_t    apb_o,
  input fetch_ctrl_t ctrl,
  input logic        deq_valid_o,
  input logic        deq_ready_i
);

  logic [FQ_CNT_W-1:0] occ_q;  // entries pushed and not yet taken

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      occ_q <= '0;
    end else if (ctrl.q_flush) begin
      occ_q <= '0;
    end else begin
      occ_q <= occ_q + FQ_CNT_W'(ctrl.q_push) - FQ_CNT_W'(deq_valid_o & deq_ready_i);
    end
  end

  // access phase only after a setup phase
  penable_after_psel: assert property (@(posedge clk) disable iff (!rst_n_i)
    $rose(apb_o.penable) |-> $past(apb_o.psel))
    else $error("penable rose without psel in the previous cycle");

  paddr_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
    (apb_o.psel && apb_o.penable) |-> $stable(apb_o.paddr))
    else $error("paddr changed during the access phase");

  // nothing to hand to decode
  empty_not_valid: assert property (@(posedge clk) disable iff (!rst_n_i)
    (occ_q == '0) |-> !deq_valid_o)
    else $error("deq_valid_o high with an empty queue");

endmodule

// File: verification/fetch_tb.sv
`timescale 1ns/10ps

module fetch_tb import fetch_pkg::*; ();

  localparam logic [ADDR_W-1:0] ERR_ADDR = 32'h8000_0300;
  localparam int TIMEOUT = 400;

  logic              clk;
  logic              rst_n;
  redirect_t         trap;
  branch_t           branch;
  logic              restart;
  apb_req_t          apb_req;
  apb_rsp_t          apb_rsp;
  logic              deq_valid;
  fetch_entry_t      deq_entry;
  logic              deq_ready;
  logic [1:0]        wait_cnt;
  logic [ADDR_W-1:0] err_addr;
  integer            seed = 79;
  fetch_entry_t      got_q[$];

  clk_gen u_clk_gen (.clk_o(clk), .rst_n_o(rst_n));

  imem_apb_model u_mem (
    .clk(clk), .rst_n_i(rst_n), .apb_req_i(apb_req), .apb_rsp_o(apb_rsp),
    .wait_i(wait_cnt), .err_addr_i(err_addr)
  );

  fetch_top dut (
    .clk(clk), .rst_n_i(rst_n), .trap_i(trap), .branch_i(branch), .restart_i(restart),
    .apb_o(apb_req), .apb_i(apb_rsp), .deq_valid_o(deq_valid), .deq_entry_o(deq_entry),
    .deq_ready_i(deq_ready)
  );

  bind fetch_top fetch_assert u_fetch_assert (.*);

  always @(posedge clk) begin
    #1 wait_cnt = 2'($random(seed));  // fresh wait states every cycle
  end

  // scoreboard input, every accepted entry
  always @(posedge clk) begin
    if (rst_n && deq_valid && deq_ready) begin
      got_q.push_back(deq_entry);
    end
  end

  task automatic report_error(input string msg);
    $display("Error: %0t ns: %s", $time, msg);
    $display("SIMULATION FAILED");
    $fatal(1);
  endtask

  task automatic timeout_fail(input string what);
    $display("Timed out after %0d cycles waiting for %s", TIMEOUT, what);
    $display("SIMULATION FAILED");
    $fatal(1);
  endtask

  task automatic wait_reset_release();
    int events = 0;
    while (rst_n !== 1'b1) begin
      if (events >= TIMEOUT) begin
        timeout_fail("reset release");
      end
      @(rst_n or posedge clk);
      events++;
    end
  endtask

  // next pc by the fetch rule: jal jumps, everything else falls through
  function automatic logic [ADDR_W-1:0] next_pc(input logic [ADDR_W-1:0] pc,
                                                 input logic [DATA_W-1:0] inst);
    logic [20:0] off;
    if (inst[6:0] != 7'h6f) begin
      return pc + 32'd4;
    end
    off = {inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
    return pc + {{11{off[20]}}, off};
  endfunction

  task automatic pop_entry(output fetch_entry_t e);
    int cycles = 0;
    while (got_q.size() == 0) begin
      if (cycles >= TIMEOUT) begin
        timeout_fail("a dequeued entry");
      end
      @(posedge clk);
      #1;
      cycles++;
    end
    e = got_q.pop_front();
  endtask

  // pops n entries and checks them against the chain starting at pc
  task automatic check_chain(inout logic [ADDR_W-1:0] pc, input int n);
    fetch_entry_t      e;
    logic [DATA_W-1:0] word;
    logic              fault_exp;
    for (int k = 0; k < n; k++) begin
      pop_entry(e);
      word = u_mem.mem[pc[9:2]];
      fault_exp = (pc == ERR_ADDR);
      assert (e.pc == pc)
        else report_error($sformatf("entry pc %h, expected %h", e.pc, pc));
      assert (e.inst == word)
        else report_error($sformatf("inst %h at %h, expected %h", e.inst, pc, word));
      assert (e.fault == fault_exp)
        else report_error($sformatf("fault %b at %h, expected %b", e.fault, pc, fault_exp));
      assert (e.pred_taken == (!fault_exp && word[6:0] == 7'h6f))
        else report_error($sformatf("pred_taken %b wrong at %h", e.pred_taken, pc));
      pc = fault_exp ? pc + 32'd4 : next_pc(pc, word);
    end
  endtask

  // one-cycle pulse, entries taken at its closing edge are older ones
  task automatic send_redirect(input redirect_t t, input branch_t b, input logic rs);
    @(posedge clk);
    #1;
    trap = t;
    branch = b;
    restart = rs;
    @(posedge clk);
    #1;
    trap = '0;
    branch = '0;
    restart = 1'b0;
    got_q.delete();
  endtask

  task automatic test_reset_seq(inout logic [ADDR_W-1:0] pc);
    assert (!apb_req.psel && !deq_valid)
      else report_error("psel or deq_valid high right after reset");
    pc = PC_RESET_ADDR;
    check_chain(pc, 4);
  endtask

  task automatic test_jal(inout logic [ADDR_W-1:0] pc);
    fetch_entry_t e;
    check_chain(pc, 1);  // 0x10 holds jal x1, +0x40
    pop_entry(e);
    assert (e.pc == 32'h8000_0050)
      else report_error($sformatf("pc %h after jal, expected 80000050", e.pc));
    pc = 32'h8000_0054;
    check_chain(pc, 4);
  endtask

  task automatic test_branch(inout logic [ADDR_W-1:0] pc);
    send_redirect('0, branch_t'{valid: 1'b1, pc: 32'h8000_0080}, 1'b0);
    pc = 32'h8000_0080;
    check_chain(pc, 5);
  endtask

  task automatic test_trap(inout logic [ADDR_W-1:0] pc);
    send_redirect(redirect_t'{valid: 1'b1, plus4: 1'b0, pc: 32'h8000_0100}, '0, 1'b0);
    pc = 32'h8000_0100;
    check_chain(pc, 3);
    send_redirect(redirect_t'{valid: 1'b1, plus4: 1'b1, pc: 32'h8000_0180}, '0, 1'b0);
    pc = 32'h8000_0184;  // fence.i
    check_chain(pc, 3);
    send_redirect(redirect_t'{valid: 1'b1, plus4: 1'b0, pc: 32'h8000_0240},
                  branch_t'{valid: 1'b1, pc: 32'h8000_0080}, 1'b0);
    pc = 32'h8000_0240;
    check_chain(pc, 3);
  endtask

  task automatic test_backpressure(inout logic [ADDR_W-1:0] pc);
    int pushes = 0;
    deq_ready = 1'b0;
    send_redirect('0, branch_t'{valid: 1'b1, pc: 32'h8000_0020}, 1'b0);
    for (int c = 0; c < 60; c++) begin
      @(posedge clk);
      if (dut.ctrl.q_push) begin
        pushes++;
      end
      if (c >= 50) begin
        assert (!apb_req.psel)
          else report_error("psel high while the queue is full");
      end
    end
    assert (pushes <= FQ_DEPTH)
      else report_error($sformatf("%0d entries pushed under back-pressure", pushes));
    #1 deq_ready = 1'b1;
    pc = 32'h8000_0020;
    check_chain(pc, 8);
  endtask

  task automatic test_fault_restart(inout logic [ADDR_W-1:0] pc);
    send_redirect('0, branch_t'{valid: 1'b1, pc: ERR_ADDR - 32'd8}, 1'b0);
    pc = ERR_ADDR - 32'd8;
    check_chain(pc, 3);  // last one faults
    send_redirect('0, '0, 1'b1);
    pc = PC_RESET_ADDR;
    check_chain(pc, 4);
  endtask

  initial begin
    logic [ADDR_W-1:0] pc;
    trap = '0;
    branch = '0;
    restart = 1'b0;
    deq_ready = 1'b1;
    wait_cnt = '0;
    err_addr = ERR_ADDR;
    pc = PC_RESET_ADDR;
    wait_reset_release();
    test_reset_seq(pc);
    test_jal(pc);
    test_branch(pc);
    test_trap(pc);
    test_backpressure(pc);
    test_fault_restart(pc);
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

// File: verification/imem_apb_model.sv
`timescale 1ns/10ps

module imem_apb_model import fetch_pkg::*; (
  input  logic              clk,
  input  logic              rst_n_i,
  input  apb_req_t          apb_req_i,
  output apb_rsp_t          apb_rsp_o,
  input  logic [1:0]        wait_i,     // wait states for the next transfer
  input  logic [ADDR_W-1:0] err_addr_i
);

  localparam int MEM_WORDS = 256;

  logic [DATA_W-1:0] mem [MEM_WORDS];
  logic [1:0]        wait_q;

  // word 4 holds jal x1, +0x40; the rest is a non-jump pattern of the address
  function automatic logic [DATA_W-1:0] fill_word(input logic [ADDR_W-1:0] addr);
    if (addr[9:2] == 8'd4) begin
      return 32'h0400_00ef;
    end
    return {addr[31:7] ^ addr[24:0], 7'h13};
  endfunction

  initial begin
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = fill_word(PC_RESET_ADDR + ADDR_W'(4 * i));
    end
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wait_q <= '0;
    end else if (apb_req_i.psel && !apb_req_i.penable) begin
      wait_q <= wait_i;  // latched in setup
    end else if (apb_req_i.psel && apb_req_i.penable && wait_q != 2'd0) begin
      wait_q <= wait_q - 2'd1;
    end
  end

  always_comb begin
    apb_rsp_o.pready  = apb_req_i.psel & apb_req_i.penable & (wait_q == 2'd0);
    apb_rsp_o.prdata  = mem[apb_req_i.paddr[9:2]];
    apb_rsp_o.pslverr = apb_rsp_o.pready & (apb_req_i.paddr == err_addr_i);
  end

endmodule
